// ==== Makefile ====
TOP = all_moves_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all_moves.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all_moves.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all_moves.f ====
source/chess_pkg.sv
source/scan_counters.sv
source/board_store.sv
source/target_calc.sv
source/move_ram.sv
source/move_gen_fsm.sv
source/all_moves.sv
bench/all_moves_props.sv
bench/all_moves_tb.sv

// ==== bench/all_moves_props.sv ====
`timescale 1ns/10ps

module all_moves_props #(
   parameter int MAX_MOVES = 256
)
(
   input logic                         clk,
   input logic                         reset,
   input logic                         clear_moves,
   input logic                         moves_ready,
   input logic [$clog2(MAX_MOVES)-1:0] move_count
);

   int fail_count = 0;

   // result stays up until the host clears it
   ready_held: assert property (@(posedge clk) disable iff (reset)
      moves_ready && !clear_moves |=> moves_ready)
   else
   begin
      $error("moves_ready fell without clear_moves");
      fail_count++;
   end

   count_stable: assert property (@(posedge clk) disable iff (reset)
      moves_ready |=> $stable(move_count))
   else
   begin
      $error("move_count changed while moves_ready was high");
      fail_count++;
   end

   idle_after_reset: assert property (@(posedge clk)
      reset |=> !moves_ready)
   else
   begin
      $error("moves_ready high right after reset");
      fail_count++;
   end

endmodule

bind all_moves all_moves_props #(
   .MAX_MOVES (MAX_MOVES)
) i_all_moves_props (
   .clk         (clk),
   .reset       (reset),
   .clear_moves (clear_moves),
   .moves_ready (moves_ready),
   .move_count  (move_count)
);

// ==== bench/all_moves_tb.sv ====
`timescale 1ns/10ps

module all_moves_tb;
   import chess_pkg::*;

   localparam int MAX_MOVES   = 256;
   localparam int IDX_W       = $clog2(MAX_MOVES);
   localparam int NUM_RANDOM  = 36;
   localparam int NUM_BOARDS  = NUM_RANDOM + 4;
   localparam int CYCLE_LIMIT = NUM_BOARDS * (64 * 60 + 300);

   // ray directions as (row, col) steps
   localparam int KNIGHT_DR [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
   localparam int KNIGHT_DC [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};
   localparam int KING_DR [8]   = '{-1, -1, -1, 0, 0, 1, 1, 1};
   localparam int KING_DC [8]   = '{-1, 0, 1, -1, 1, -1, 0, 1};
   localparam int ROOK_DR [4]   = '{0, 0, 1, -1};
   localparam int ROOK_DC [4]   = '{1, -1, 0, 0};
   localparam int BISHOP_DR [4] = '{1, 1, -1, -1};
   localparam int BISHOP_DC [4] = '{1, -1, 1, -1};

   logic             clk;
   logic             reset;
   logic             board_valid;
   board_t           board_in;
   logic             white_to_move_in;
   logic             clear_moves;
   logic [IDX_W-1:0] move_index;
   logic             moves_ready;
   logic [IDX_W-1:0] move_count;
   logic             move_ready;
   move_t            move_out;

   logic [31:0] rng_state;
   int          cycles = 0;
   int          err_count = 0;
   int          check_count = 0;
   int          test_count = 0;

   logic [5:0] exp_from [MAX_MOVES];
   logic [5:0] exp_to [MAX_MOVES];
   piece_t     exp_piece [MAX_MOVES];
   logic       exp_cap [MAX_MOVES];
   int         exp_count;

   all_moves #(
      .MAX_MOVES (MAX_MOVES)
   ) i_all_moves (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .move_index       (move_index),
      .moves_ready      (moves_ready),
      .move_count       (move_count),
      .move_ready       (move_ready),
      .move_out         (move_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout: the run went past its limit of %0d clock cycles", CYCLE_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic piece_t piece_at(board_t b, int row, int col);
      return b[(row * 8 + col) * 4 +: 4];
   endfunction

   function automatic logic on_board(int row, int col);
      return row >= 0 && row < 8 && col >= 0 && col < 8;
   endfunction

   task automatic add_move(int from_sq, int to_sq, piece_t piece, logic cap);
      if (exp_count < MAX_MOVES)
      begin
         exp_from[exp_count]  = 6'(from_sq);
         exp_to[exp_count]    = 6'(to_sq);
         exp_piece[exp_count] = piece;
         exp_cap[exp_count]   = cap;
         exp_count++;
      end
   endtask

   task automatic ray_offset(logic [2:0] ptype, int d, output int dr, output int dc);
      case (ptype)
         PIECE_KNIGHT:
         begin
            dr = KNIGHT_DR[d];
            dc = KNIGHT_DC[d];
         end
         PIECE_BISHOP:
         begin
            dr = BISHOP_DR[d];
            dc = BISHOP_DC[d];
         end
         PIECE_ROOK:
         begin
            dr = ROOK_DR[d];
            dc = ROOK_DC[d];
         end
         default:  // queen and king share the eight neighbours
         begin
            dr = KING_DR[d];
            dc = KING_DC[d];
         end
      endcase
   endtask

   task automatic model_square(board_t b, logic white, int sq);
      piece_t     p;
      piece_t     t;
      logic [2:0] ptype;
      int         row;
      int         col;
      int         fwd;
      int         ndir;
      int         max_step;
      int         d;
      int         s;
      int         dr;
      int         dc;
      int         r;
      int         c;
      logic       blocked;
      logic       adv_free;
      row   = sq / 8;
      col   = sq % 8;
      p     = piece_at(b, row, col);
      ptype = p[2:0];
      fwd   = white ? 1 : -1;
      if (ptype == PIECE_EMPTY || p[BLACK_BIT] != !white)
         return;
      if (ptype == PIECE_PAWN)
      begin
         if (row + fwd == (white ? 7 : 0))
            return;  // would promote
         t        = piece_at(b, row + fwd, col);
         adv_free = t[2:0] == PIECE_EMPTY;
         if (adv_free)
            add_move(sq, (row + fwd) * 8 + col, p, 1'b0);
         if (row == (white ? 1 : 6) && adv_free)
         begin
            t = piece_at(b, row + 2 * fwd, col);
            if (t[2:0] == PIECE_EMPTY)
               add_move(sq, (row + 2 * fwd) * 8 + col, p, 1'b0);
         end
         for (dc = -1; dc <= 1; dc += 2)
         begin
            if (on_board(row + fwd, col + dc))
            begin
               t = piece_at(b, row + fwd, col + dc);
               if (t[2:0] != PIECE_EMPTY && t[BLACK_BIT] == white)
                  add_move(sq, (row + fwd) * 8 + col + dc, p, 1'b1);
            end
         end
         return;
      end
      ndir     = (ptype == PIECE_BISHOP || ptype == PIECE_ROOK) ? 4 : 8;
      max_step = (ptype == PIECE_KNIGHT || ptype == PIECE_KING) ? 1 : 7;
      for (d = 0; d < ndir; d++)
      begin
         ray_offset(ptype, d, dr, dc);
         blocked = 1'b0;
         for (s = 1; s <= max_step && !blocked; s++)
         begin
            r = row + s * dr;
            c = col + s * dc;
            if (!on_board(r, c))
               blocked = 1'b1;
            else
            begin
               t = piece_at(b, r, c);
               if (t[2:0] == PIECE_EMPTY)
                  add_move(sq, r * 8 + c, p, 1'b0);
               else
               begin
                  if (t[BLACK_BIT] == white)  // opponent
                     add_move(sq, r * 8 + c, p, 1'b1);
                  blocked = 1'b1;
               end
            end
         end
      end
   endtask

   task automatic random_board(output board_t b);
      logic [31:0] r;
      logic [2:0]  ptype;
      int          sq;
      b = '0;
      for (sq = 0; sq < 64; sq++)
      begin
         r = next_random();
         if (r[31:30] == 2'b00)  // about one square in four
         begin
            ptype = 3'(1 + r[29:16] % 6);
            if (!(ptype == PIECE_PAWN && (sq < 8 || sq >= 56)))
               b[sq * 4 +: 4] = {r[15], ptype};
         end
      end
   endtask

   task automatic read_move(string name, int idx, logic white);
      move_index = IDX_W'(idx);
      @(negedge clk);  // one cycle of read latency
      check_count++;
      assert (move_ready)
      else
      begin
         $display("ERR %0t %s: move_ready low one cycle after move_index %0d was set",
                  $time, name, idx);
         err_count++;
      end
      assert (move_out.from_sq == exp_from[idx] && move_out.to_sq == exp_to[idx] &&
              move_out.piece == exp_piece[idx])
      else
      begin
         $display("ERR %0t %s: move %0d is %0d->%0d piece %h, expected %0d->%0d piece %h",
                  $time, name, idx, move_out.from_sq, move_out.to_sq, move_out.piece,
                  exp_from[idx], exp_to[idx], exp_piece[idx]);
         err_count++;
      end
      assert (move_out.capture == exp_cap[idx])
      else
      begin
         $display("ERR %0t %s: move %0d capture flag %b, expected %b",
                  $time, name, idx, move_out.capture, exp_cap[idx]);
         err_count++;
      end
      assert (move_out.piece[BLACK_BIT] == !white)
      else
      begin
         $display("ERR %0t %s: move %0d moves a piece of the wrong side", $time, name, idx);
         err_count++;
      end
   endtask

   task automatic check_board(string name, board_t b, logic white, int fixed_count);
      int errs_before;
      int sq;
      int i;
      errs_before = err_count;
      exp_count   = 0;
      for (sq = 0; sq < 64; sq++)
         model_square(b, white, sq);
      @(negedge clk);
      board_in         = b;
      white_to_move_in = white;
      board_valid      = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      while (!moves_ready)
         @(negedge clk);
      check_count++;
      assert (int'(move_count) == exp_count)
      else
      begin
         $display("ERR %0t %s: move_count %0d, expected %0d", $time, name, move_count, exp_count);
         err_count++;
      end
      if (fixed_count >= 0)
      begin
         check_count++;
         assert (int'(move_count) == fixed_count)
         else
         begin
            $display("ERR %0t %s: move_count %0d, expected %0d for this position",
                     $time, name, move_count, fixed_count);
            err_count++;
         end
      end
      for (i = 0; i < exp_count; i++)
         read_move(name, i, white);
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      check_count++;
      assert (!moves_ready)
      else
      begin
         $display("ERR %0t %s: moves_ready still high after clear_moves", $time, name);
         err_count++;
      end
      test_count++;
      $display("test %0d %s: %0d moves, %0d errors", test_count, name, exp_count,
               err_count - errs_before);
   endtask

   initial
   begin
      board_t b;
      int     n;
      rng_state        = 32'd69937;
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b1;
      clear_moves      = 1'b0;
      move_index       = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (n = 0; n < NUM_RANDOM; n++)
      begin
         random_board(b);
         check_board((n % 2 == 0) ? "random white" : "random black", b, n % 2 == 0, -1);
      end

      b = '0;  // black pieces only, white to move
      b[0 * 4 +: 4]  = {1'b1, PIECE_ROOK};
      b[4 * 4 +: 4]  = {1'b1, PIECE_KING};
      b[52 * 4 +: 4] = {1'b1, PIECE_PAWN};
      check_board("no own pieces", b, 1'b1, 0);

      b = '0;
      b[12 * 4 +: 4] = {1'b0, PIECE_PAWN};
      check_board("white pawn on start row", b, 1'b1, 2);

      b = '0;
      b[51 * 4 +: 4] = {1'b1, PIECE_PAWN};
      check_board("black pawn on start row", b, 1'b0, 2);

      b = '0;
      b[52 * 4 +: 4] = {1'b0, PIECE_PAWN};
      check_board("pawn before promotion", b, 1'b1, 0);

      if (i_all_moves.i_all_moves_props.fail_count != 0)
      begin
         $display("protocol assertions failed %0d times", i_all_moves.i_all_moves_props.fail_count);
         err_count += i_all_moves.i_all_moves_props.fail_count;
      end
      $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== source/all_moves.sv ====
`timescale 1ns/10ps

module all_moves #(
   parameter int MAX_MOVES = 256
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         board_valid,
   input  chess_pkg::board_t            board_in,
   input  logic                         white_to_move_in,
   input  logic                         clear_moves,
   input  logic [$clog2(MAX_MOVES)-1:0] move_index,
   output logic                         moves_ready,
   output logic [$clog2(MAX_MOVES)-1:0] move_count,
   output logic                         move_ready,
   output chess_pkg::move_t             move_out
);
   import chess_pkg::*;

   logic       load;
   logic       start;
   logic       clear;
   logic       next_square;
   logic       next_dir;
   logic       next_step;
   logic       wr_en;
   logic       full;
   logic       last_square;
   logic       off_board;
   logic       white_to_move;
   logic [2:0] step;
   square_t    square;
   square_t    target_square;
   dir_t       dir;
   piece_t     from_piece;
   piece_t     target_piece;
   move_t      wr_move;

   move_gen_fsm #(
      .MAX_MOVES (MAX_MOVES)
   ) i_move_gen_fsm (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .clear_moves   (clear_moves),
      .square        (square),
      .from_piece    (from_piece),
      .target_piece  (target_piece),
      .target_square (target_square),
      .off_board     (off_board),
      .white_to_move (white_to_move),
      .last_square   (last_square),
      .dir           (dir),
      .step          (step),
      .full          (full),
      .load          (load),
      .start         (start),
      .next_square   (next_square),
      .next_dir      (next_dir),
      .next_step     (next_step),
      .wr_en         (wr_en),
      .wr_move       (wr_move),
      .clear         (clear),
      .moves_ready   (moves_ready)
   );

   scan_counters i_scan_counters (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .next_square (next_square),
      .next_dir    (next_dir),
      .next_step   (next_step),
      .square      (square),
      .dir         (dir),
      .step        (step),
      .last_square (last_square)
   );

   board_store i_board_store (
      .clk              (clk),
      .reset            (reset),
      .load             (load),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .square           (square),
      .target_square    (target_square),
      .from_piece       (from_piece),
      .target_piece     (target_piece),
      .white_to_move    (white_to_move)
   );

   target_calc i_target_calc (
      .square        (square),
      .dir           (dir),
      .step          (step),
      .from_piece    (from_piece),
      .white_to_move (white_to_move),
      .target_square (target_square),
      .off_board     (off_board)
   );

   move_ram #(
      .MAX_MOVES (MAX_MOVES)
   ) i_move_ram (
      .clk        (clk),
      .reset      (reset),
      .clear      (clear),
      .wr_en      (wr_en),
      .wr_move    (wr_move),
      .move_index (move_index),
      .move_out   (move_out),
      .move_ready (move_ready),
      .move_count (move_count),
      .full       (full)
   );

endmodule

// ==== source/board_store.sv ====
`timescale 1ns/10ps

module board_store
(
   input  logic               clk,
   input  logic               reset,
   input  logic               load,
   input  chess_pkg::board_t  board_in,
   input  logic               white_to_move_in,
   input  chess_pkg::square_t square,
   input  chess_pkg::square_t target_square,
   output chess_pkg::piece_t  from_piece,
   output chess_pkg::piece_t  target_piece,
   output logic               white_to_move
);
   import chess_pkg::*;

   board_t board;

   always_ff @(posedge clk)
   begin
      if (load)
         board <= board_in;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         white_to_move <= 1'b1;
      else if (load)
         white_to_move <= white_to_move_in;
   end

   // four bits per square
   assign from_piece   = board[{square, 2'b00} +: 4];
   assign target_piece = board[{target_square, 2'b00} +: 4];

endmodule

// ==== source/chess_pkg.sv ====
package chess_pkg;

   typedef logic [3:0] piece_t;       // bit 3 black, 2..0 type
   typedef logic [5:0] square_t;      // row * 8 + col
   typedef logic [255:0] board_t;     // square n at 4n+3..4n
   typedef logic [2:0] dir_t;
   typedef logic signed [2:0] offset_t;

   localparam logic [2:0] PIECE_EMPTY  = 3'd0;
   localparam logic [2:0] PIECE_PAWN   = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK   = 3'd4;
   localparam logic [2:0] PIECE_QUEEN  = 3'd5;
   localparam logic [2:0] PIECE_KING   = 3'd6;

   localparam int BLACK_BIT = 3;

   typedef struct packed {
      square_t from_sq;
      square_t to_sq;
      piece_t  piece;
      logic    capture;
   } move_t;

   // indexed [type][dir], pawn rows in white terms
   localparam offset_t ROW_OFFSETS [8][8] = '{
      '{ 0,  0,  0,  0,  0,  0,  0,  0},
      '{ 1,  2,  1,  1,  0,  0,  0,  0},  // pawn
      '{-2, -1,  1,  2,  2,  1, -1, -2},  // knight
      '{ 1,  1, -1, -1,  0,  0,  0,  0},  // bishop
      '{ 0,  0,  1, -1,  0,  0,  0,  0},  // rook
      '{-1, -1, -1,  0,  0,  1,  1,  1},  // queen
      '{-1, -1, -1,  0,  0,  1,  1,  1},  // king
      '{ 0,  0,  0,  0,  0,  0,  0,  0}
   };

   localparam offset_t COL_OFFSETS [8][8] = '{
      '{ 0,  0,  0,  0,  0,  0,  0,  0},
      '{ 0,  0, -1,  1,  0,  0,  0,  0},  // advance, double, left, right
      '{-1, -2, -2, -1,  1,  2,  2,  1},
      '{ 1, -1,  1, -1,  0,  0,  0,  0},
      '{ 1, -1,  0,  0,  0,  0,  0,  0},
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{ 0,  0,  0,  0,  0,  0,  0,  0}
   };

   localparam logic [3:0] DIR_COUNT [8] = '{0, 4, 8, 4, 4, 8, 8, 0};

   localparam logic [7:0] SLIDES = 8'b0011_1000;  // bishop, rook, queen

endpackage

// ==== source/move_gen_fsm.sv ====
`timescale 1ns/10ps

module move_gen_fsm #(
   parameter int MAX_MOVES = 256
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               board_valid,
   input  logic               clear_moves,
   input  chess_pkg::square_t square,
   input  chess_pkg::piece_t  from_piece,
   input  chess_pkg::piece_t  target_piece,
   input  chess_pkg::square_t target_square,
   input  logic               off_board,
   input  logic               white_to_move,
   input  logic               last_square,
   input  chess_pkg::dir_t    dir,
   input  logic [2:0]         step,
   input  logic               full,
   output logic               load,
   output logic               start,
   output logic               next_square,
   output logic               next_dir,
   output logic               next_step,
   output logic               wr_en,
   output chess_pkg::move_t   wr_move,
   output logic               clear,
   output logic               moves_ready
);
   import chess_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_SQUARE,
      S_TRY,
      S_NEXT_DIR,
      S_DONE
   } state_t;

   state_t     state;
   state_t     state_nxt;
   logic [2:0] ptype;
   logic [2:0] row;
   logic [2:0] start_row;
   logic [2:0] last_row;
   logic       own_piece;
   logic       target_empty;
   logic       target_own;
   logic       candidate;
   logic       keep_sliding;
   logic       last_dir;
   logic       adv_ok;  // single advance square free

   if (MAX_MOVES < 256 || (MAX_MOVES & (MAX_MOVES - 1)) != 0)
   begin : g_depth_check
      $error("MAX_MOVES must be a power of two, at least 256");
   end

   assign ptype        = from_piece[2:0];
   assign row          = square[5:3];
   assign own_piece    = ptype != PIECE_EMPTY && from_piece[BLACK_BIT] == !white_to_move;
   assign start_row    = white_to_move ? 3'd1 : 3'd6;
   assign last_row     = white_to_move ? 3'd6 : 3'd1;  // next push promotes
   assign target_empty = target_piece[2:0] == PIECE_EMPTY;
   assign target_own   = !target_empty && target_piece[BLACK_BIT] == !white_to_move;
   assign last_dir     = {1'b0, dir} == DIR_COUNT[ptype] - 4'd1;
   assign keep_sliding = SLIDES[ptype] && !off_board && target_empty && step != 3'd7;

   always_comb
   begin
      if (ptype == PIECE_PAWN)
      begin
         case (dir)
            3'd0:    candidate = !off_board && target_empty;
            3'd1:    candidate = !off_board && target_empty && adv_ok && row == start_row;
            default: candidate = !off_board && !target_empty && !target_own;
         endcase
      end
      else
         candidate = !off_board && !target_own;
   end

   always_comb
   begin
      state_nxt   = state;
      load        = 1'b0;
      start       = 1'b0;
      clear       = 1'b0;
      next_square = 1'b0;
      next_dir    = 1'b0;
      next_step   = 1'b0;
      wr_en       = 1'b0;
      case (state)
         S_IDLE:
         begin
            if (board_valid)
            begin
               load      = 1'b1;
               state_nxt = S_LOAD;
            end
         end
         S_LOAD:
         begin
            start     = 1'b1;
            clear     = 1'b1;
            state_nxt = S_SQUARE;
         end
         S_SQUARE:
         begin
            if (own_piece && !(ptype == PIECE_PAWN && row == last_row))
            begin
               next_step = 1'b1;  // step 0 -> 1 on dir 0
               state_nxt = S_TRY;
            end
            else if (last_square)
               state_nxt = S_DONE;
            else
               next_square = 1'b1;
         end
         S_TRY:
         begin
            wr_en = candidate && !full;  // drop once memory is full
            if (keep_sliding)
               next_step = 1'b1;
            else
               state_nxt = S_NEXT_DIR;
         end
         S_NEXT_DIR:
         begin
            if (!last_dir)
            begin
               next_dir  = 1'b1;
               state_nxt = S_TRY;
            end
            else if (last_square)
               state_nxt = S_DONE;
            else
            begin
               next_square = 1'b1;
               state_nxt   = S_SQUARE;
            end
         end
         S_DONE:
         begin
            if (clear_moves)
               state_nxt = S_IDLE;
         end
         default:
            state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= S_IDLE;
      else
         state <= state_nxt;
   end

   // double advance looks at the result of dir 0
   always_ff @(posedge clk)
   begin
      if (reset)
         adv_ok <= 1'b0;
      else if (state == S_TRY && ptype == PIECE_PAWN && dir == 3'd0)
         adv_ok <= candidate;
   end

   assign wr_move.from_sq = square;
   assign wr_move.to_sq   = target_square;
   assign wr_move.piece   = from_piece;
   assign wr_move.capture = !target_empty;

   assign moves_ready = state == S_DONE;

endmodule

// ==== source/move_ram.sv ====
`timescale 1ns/10ps

module move_ram #(
   parameter int MAX_MOVES = 256
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         clear,
   input  logic                         wr_en,
   input  chess_pkg::move_t             wr_move,
   input  logic [$clog2(MAX_MOVES)-1:0] move_index,
   output chess_pkg::move_t             move_out,
   output logic                         move_ready,
   output logic [$clog2(MAX_MOVES)-1:0] move_count,
   output logic                         full
);
   import chess_pkg::*;

   localparam int CNT_W = $clog2(MAX_MOVES);

   move_t            mem [MAX_MOVES];
   logic [CNT_W-1:0] wr_ptr;
   logic [CNT_W-1:0] index_q;

   always_ff @(posedge clk)
   begin
      if (reset || clear)
         wr_ptr <= '0;
      else if (wr_en)
         wr_ptr <= wr_ptr + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_move;
      move_out <= mem[move_index];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         index_q <= '0;
      else
         index_q <= move_index;
   end

   assign move_ready = move_index == index_q;  // read caught up with the index
   assign move_count = wr_ptr;
   assign full       = wr_ptr == CNT_W'(MAX_MOVES - 1);

endmodule

// ==== source/scan_counters.sv ====
`timescale 1ns/10ps

module scan_counters
(
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  logic               next_square,
   input  logic               next_dir,
   input  logic               next_step,
   output chess_pkg::square_t square,
   output chess_pkg::dir_t    dir,
   output logic [2:0]         step,
   output logic               last_square
);

   always_ff @(posedge clk)
   begin
      if (reset || start)
      begin
         square <= '0;
         dir    <= '0;
         step   <= '0;
      end
      else if (next_square)
      begin
         square <= square + 6'd1;
         dir    <= '0;
         step   <= '0;
      end
      else if (next_dir)
      begin
         dir  <= dir + 3'd1;
         step <= 3'd1;  // first square of the new ray
      end
      else if (next_step)
         step <= step + 3'd1;
   end

   assign last_square = square == 6'd63;

endmodule

// ==== source/target_calc.sv ====
`timescale 1ns/10ps

module target_calc
(
   input  chess_pkg::square_t square,
   input  chess_pkg::dir_t    dir,
   input  logic [2:0]         step,
   input  chess_pkg::piece_t  from_piece,
   input  logic               white_to_move,
   output chess_pkg::square_t target_square,
   output logic               off_board
);
   import chess_pkg::*;

   logic [2:0]        ptype;
   offset_t           row_tab;
   offset_t           col_tab;
   logic signed [5:0] row_off;
   logic signed [5:0] col_off;
   logic signed [5:0] step_s;
   logic signed [5:0] t_row;
   logic signed [5:0] t_col;

   always_comb
   begin
      ptype   = from_piece[2:0];
      row_tab = ROW_OFFSETS[ptype][dir];
      col_tab = COL_OFFSETS[ptype][dir];
      row_off = {{3{row_tab[2]}}, row_tab};
      col_off = {{3{col_tab[2]}}, col_tab};

      // black pawns run down the board
      if (ptype == PIECE_PAWN && !white_to_move)
         row_off = -row_off;

      step_s = $signed({3'b000, step});
      t_row  = $signed({3'b000, square[5:3]}) + step_s * row_off;
      t_col  = $signed({3'b000, square[2:0]}) + step_s * col_off;
   end

   assign off_board = (t_row < 6'sd0) || (t_row > 6'sd7) ||
                      (t_col < 6'sd0) || (t_col > 6'sd7);

   assign target_square = {t_row[2:0], t_col[2:0]};  // don't care when off board

endmodule
